// ==== common/mipsPkg.sv ====
package mipsPkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    typedef logic [31:0] wordT;        // data word or instruction
    typedef logic [4:0]  regAddrT;     // register number
    typedef logic [5:0]  imemAddrT;    // instruction word index
    typedef logic [4:0]  dmemAddrT;    // data word index, byte address bits 6..2
    typedef logic [2:0]  aluOpT;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 32;

    // ----------------------------------------
    // alu operation codes
    // ----------------------------------------
    localparam aluOpT ALU_ADD = 3'd0;
    localparam aluOpT ALU_SUB = 3'd1;
    localparam aluOpT ALU_AND = 3'd2;
    localparam aluOpT ALU_OR  = 3'd3;
    localparam aluOpT ALU_XOR = 3'd4;
    localparam aluOpT ALU_SLT = 3'd5;
    localparam aluOpT ALU_LUI = 3'd6;  // immediate into upper half

    // ----------------------------------------
    // opcodes and function codes
    // ----------------------------------------
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;  // all ones, end of program

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // ----------------------------------------
    // records between stages
    // ----------------------------------------
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        imemAddrT adr;
        wordT     dat;
    } wbReqT;

    typedef struct packed {
        logic    valid;
        logic    halt;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    useImm;    // operand b from imm
        aluOpT   aluOp;
        regAddrT rs;
        regAddrT rt;
        regAddrT dst;
        wordT    opA;
        wordT    opB;
        wordT    imm;       // already extended
    } idExT;

    typedef struct packed {
        logic    valid;
        logic    halt;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        regAddrT dst;
        wordT    result;    // alu result or byte address
        wordT    storeData;
    } exMemT;

    typedef struct packed {
        logic    valid;
        regAddrT dst;
        wordT    data;
    } regWriteT;

endpackage

// ==== fetch/instructionFetch.sv ====
`timescale 1ns/10ps

module instructionFetch (
    input  logic           clk,
    input  logic           i_reset,
    input  logic           i_halt,
    input  mipsPkg::wbReqT i_wbReq,
    input  logic           i_stall,
    input  logic           i_haltSeen,
    output logic           o_wbAck,
    output mipsPkg::wordT  o_instr,
    output logic           o_instrValid
);
    import mipsPkg::*;

    wordT     instrMem [IMEM_WORDS];
    imemAddrT pc;
    logic     haltLatched;   // halt went by and fetching stops
    logic     wbWrite;
    logic     fetchStopped;

    // ----------------------------------------
    // wishbone program load
    // ----------------------------------------

    // write on the first cycle of stb only, the ack blocks a repeat
    assign wbWrite = i_wbReq.cyc && i_wbReq.stb && i_wbReq.we && !o_wbAck;

    always_ff @(posedge clk) begin
        if (wbWrite) begin
            instrMem[i_wbReq.adr] <= i_wbReq.dat;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wbAck <= 1'b0;
        end else begin
            o_wbAck <= wbWrite;   // single cycle pulse
        end
    end

    // ----------------------------------------
    // program counter and IF/ID
    // ----------------------------------------
    assign fetchStopped = haltLatched || i_haltSeen;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc           <= '0;
            o_instr      <= '0;
            o_instrValid <= 1'b0;
            haltLatched  <= 1'b0;
        end else if (!i_halt) begin
            if (i_haltSeen) begin
                haltLatched <= 1'b1;
            end
            if (!i_stall) begin             // stall holds pc and IF/ID
                if (fetchStopped) begin
                    o_instrValid <= 1'b0;   // bubbles after halt
                end else begin
                    o_instr      <= instrMem[pc];
                    o_instrValid <= 1'b1;
                    pc           <= pc + imemAddrT'(1);
                end
            end
        end
    end

endmodule

// ==== decode/instructionDecode.sv ====
`timescale 1ns/10ps

module instructionDecode (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_halt,
    input  mipsPkg::wordT     i_instr,
    input  logic              i_instrValid,
    input  mipsPkg::exMemT    i_exMem,
    input  mipsPkg::regWriteT i_regWrite,
    output mipsPkg::idExT     o_idEx,
    output logic              o_stall,
    output logic              o_haltSeen
);
    import mipsPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    regAddrT     rs;
    regAddrT     rt;
    regAddrT     rd;
    wordT        regFile [32];
    wordT        rsData;
    wordT        rtData;
    idExT        idExNext;
    logic        useRs;
    logic        useRt;
    logic        signExt;
    logic        loadHazard;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign funct  = i_instr[5:0];
    assign imm16  = i_instr[15:0];

    // ----------------------------------------
    // register file, write bypassed to read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (!i_halt && i_regWrite.valid && i_regWrite.dst != '0) begin
            regFile[i_regWrite.dst] <= i_regWrite.data;
        end
    end

    assign rsData = (i_regWrite.valid && i_regWrite.dst == rs && rs != '0) ?
                    i_regWrite.data : regFile[rs];
    assign rtData = (i_regWrite.valid && i_regWrite.dst == rt && rt != '0) ?
                    i_regWrite.data : regFile[rt];

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        idExNext = '0;
        useRs    = 1'b0;
        useRt    = 1'b0;
        signExt  = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                useRs             = 1'b1;
                useRt             = 1'b1;
                idExNext.dst      = rd;
                idExNext.regWrite = 1'b1;
                case (funct)
                    FN_ADDU: idExNext.aluOp = ALU_ADD;
                    FN_SUBU: idExNext.aluOp = ALU_SUB;
                    FN_AND:  idExNext.aluOp = ALU_AND;
                    FN_OR:   idExNext.aluOp = ALU_OR;
                    FN_XOR:  idExNext.aluOp = ALU_XOR;
                    FN_SLT:  idExNext.aluOp = ALU_SLT;
                    default: idExNext.regWrite = 1'b0;   // unknown funct acts as nop
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
                useRs             = (opcode != OP_LUI);
                signExt           = (opcode == OP_ADDIU) || (opcode == OP_LW);
                idExNext.dst      = rt;
                idExNext.regWrite = 1'b1;
                idExNext.useImm   = 1'b1;
                idExNext.memRead  = (opcode == OP_LW);
                if (opcode == OP_ANDI) begin
                    idExNext.aluOp = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    idExNext.aluOp = ALU_OR;
                end else if (opcode == OP_LUI) begin
                    idExNext.aluOp = ALU_LUI;
                end
            end
            OP_SW: begin
                useRs             = 1'b1;
                useRt             = 1'b1;   // store data
                signExt           = 1'b1;
                idExNext.useImm   = 1'b1;
                idExNext.memWrite = 1'b1;
            end
            OP_HALT:  idExNext.halt = 1'b1;
            default:  idExNext.halt = 1'b0;
        endcase
        idExNext.valid = 1'b1;
        idExNext.rs    = rs;
        idExNext.rt    = rt;
        idExNext.opA   = rsData;
        idExNext.opB   = rtData;
        idExNext.imm   = signExt ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};
        if (!i_instrValid) begin
            idExNext = '0;
        end
    end

    // ----------------------------------------
    // load-use hazard and ID/EX
    // ----------------------------------------
    assign loadHazard = i_instrValid && o_idEx.valid && o_idEx.memRead &&
                        (o_idEx.dst != '0) &&
                        ((useRs && o_idEx.dst == rs) || (useRt && o_idEx.dst == rt));
    assign o_stall = loadHazard;

    // fetch stays quiet while a halt is anywhere ahead
    assign o_haltSeen = (i_instrValid && opcode == OP_HALT) ||
                        (o_idEx.valid && o_idEx.halt) ||
                        (i_exMem.valid && i_exMem.halt);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_idEx <= '0;
        end else if (!i_halt) begin
            o_idEx <= loadHazard ? '0 : idExNext;   // bubble while the load finishes
        end
    end

endmodule

// ==== execute/instructionExecute.sv ====
`timescale 1ns/10ps

module instructionExecute (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_halt,
    input  mipsPkg::idExT     i_idEx,
    input  mipsPkg::regWriteT i_wbForward,
    output mipsPkg::exMemT    o_exMem
);
    import mipsPkg::*;

    wordT  fwdA;
    wordT  fwdB;
    wordT  aluA;
    wordT  aluB;
    wordT  aluResult;
    exMemT exMemNext;

    // ----------------------------------------
    // forwarding
    // ----------------------------------------

    // EX/MEM first, then MEM/WB, else the value read in decode
    function automatic wordT forwardOperand(
        input regAddrT  src,
        input wordT     regVal,
        input exMemT    exMem,
        input regWriteT wb
    );
        if (exMem.valid && exMem.regWrite && !exMem.memRead &&
            exMem.dst != '0 && exMem.dst == src) begin
            return exMem.result;
        end else if (wb.valid && wb.dst != '0 && wb.dst == src) begin
            return wb.data;      // also carries load data
        end
        return regVal;
    endfunction

    assign fwdA = forwardOperand(i_idEx.rs, i_idEx.opA, o_exMem, i_wbForward);
    assign fwdB = forwardOperand(i_idEx.rt, i_idEx.opB, o_exMem, i_wbForward);

    // ----------------------------------------
    // alu
    // ----------------------------------------
    assign aluA = fwdA;
    assign aluB = i_idEx.useImm ? i_idEx.imm : fwdB;

    always_comb begin
        case (i_idEx.aluOp)
            ALU_ADD: aluResult = aluA + aluB;
            ALU_SUB: aluResult = aluA - aluB;
            ALU_AND: aluResult = aluA & aluB;
            ALU_OR:  aluResult = aluA | aluB;
            ALU_XOR: aluResult = aluA ^ aluB;
            ALU_SLT: aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            ALU_LUI: aluResult = {aluB[15:0], 16'b0};
            default: aluResult = '0;
        endcase
    end

    // ----------------------------------------
    // EX/MEM
    // ----------------------------------------
    always_comb begin
        exMemNext           = '0;
        exMemNext.valid     = i_idEx.valid;
        exMemNext.halt      = i_idEx.halt;
        exMemNext.regWrite  = i_idEx.regWrite;
        exMemNext.memRead   = i_idEx.memRead;
        exMemNext.memWrite  = i_idEx.memWrite;
        exMemNext.dst       = i_idEx.dst;
        exMemNext.result    = aluResult;
        exMemNext.storeData = fwdB;        // forwarded rt for sw
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_exMem <= '0;
        end else if (!i_halt) begin
            o_exMem <= exMemNext;
        end
    end

endmodule

// ==== memory/memoryAccess.sv ====
`timescale 1ns/10ps

module memoryAccess (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_halt,
    input  mipsPkg::exMemT    i_exMem,
    output mipsPkg::regWriteT o_regWrite,
    output logic              o_end
);
    import mipsPkg::*;

    wordT     dataMem [DMEM_WORDS];
    dmemAddrT dataAddr;
    wordT     loadData;
    regWriteT wbReg;       // MEM/WB
    logic     endFlag;

    assign dataAddr = i_exMem.result[6:2];   // word index from byte address
    assign loadData = dataMem[dataAddr];

    // ----------------------------------------
    // data memory
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dataMem[i] <= '0;
            end
        end else if (!i_halt && i_exMem.valid && i_exMem.memWrite) begin
            dataMem[dataAddr] <= i_exMem.storeData;
        end
    end

    // ----------------------------------------
    // MEM/WB and write-back select
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wbReg.valid <= 1'b0;
            endFlag     <= 1'b0;
        end else if (!i_halt) begin
            // r0 writes never leave this stage
            wbReg.valid <= i_exMem.valid && i_exMem.regWrite && (i_exMem.dst != '0);
            wbReg.dst   <= i_exMem.dst;
            wbReg.data  <= i_exMem.memRead ? loadData : i_exMem.result;
            if (i_exMem.valid && i_exMem.halt) begin
                endFlag <= 1'b1;      // sticky until reset
            end
        end
    end

    // a held entry retires on the first edge after the freeze
    always_comb begin
        o_regWrite       = wbReg;
        o_regWrite.valid = wbReg.valid && !i_halt;
    end

    assign o_end = endFlag;

endmodule

// ==== src/pipeline.sv ====
`timescale 1ns/10ps

module pipeline (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_halt,
    input  mipsPkg::wbReqT    i_wbReq,
    output logic              o_wbAck,
    output mipsPkg::regWriteT o_retire,
    output logic              o_end
);
    import mipsPkg::*;

    wordT  instrIF2ID;
    logic  instrValidIF2ID;
    idExT  idExID2EX;
    exMemT exMemEX2MEM;
    logic  stallID2IF;
    logic  haltSeenID2IF;

    // ----------------------------------------
    // stages
    // ----------------------------------------
    instructionFetch ifInst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_halt       (i_halt),
        .i_wbReq      (i_wbReq),
        .i_stall      (stallID2IF),
        .i_haltSeen   (haltSeenID2IF),
        .o_wbAck      (o_wbAck),
        .o_instr      (instrIF2ID),
        .o_instrValid (instrValidIF2ID)
    );

    instructionDecode idInst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_halt       (i_halt),
        .i_instr      (instrIF2ID),
        .i_instrValid (instrValidIF2ID),
        .i_exMem      (exMemEX2MEM),    // load-use check
        .i_regWrite   (o_retire),       // write-back into the register file
        .o_idEx       (idExID2EX),
        .o_stall      (stallID2IF),
        .o_haltSeen   (haltSeenID2IF)
    );

    instructionExecute exInst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_halt       (i_halt),
        .i_idEx       (idExID2EX),
        .i_wbForward  (o_retire),       // MEM/WB forward source
        .o_exMem      (exMemEX2MEM)
    );

    memoryAccess memInst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_halt       (i_halt),
        .i_exMem      (exMemEX2MEM),
        .o_regWrite   (o_retire),
        .o_end        (o_end)
    );

endmodule

// ==== tb/mipsModel.svh ====
// ----------------------------------------
// galois lfsr, one step per bit taken
// ----------------------------------------
logic [31:0] lfsrState;

function automatic logic lfsrStep();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
        lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return outBit;
endfunction

function automatic logic [31:0] randBits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
        value = {value[30:0], lfsrStep()};
    end
    return value;
endfunction

// ----------------------------------------
// random program
// ----------------------------------------
wordT     progMem [PROG_LEN];
regWriteT expQ [$];     // expected writes, program order

function automatic logic [5:0] pickFunct();
    logic [31:0] sel;
    sel = randBits(3) % 6;
    case (sel)
        0: return FN_ADDU;
        1: return FN_SUBU;
        2: return FN_AND;
        3: return FN_OR;
        4: return FN_XOR;
        default: return FN_SLT;
    endcase
endfunction

task automatic buildProgram();
    int          slot;
    logic [31:0] kind;
    regAddrT     rs;
    regAddrT     rt;
    regAddrT     rd;
    logic [15:0] imm;
    logic [15:0] offset;
    logic [5:0]  fn;
    slot = 0;
    while (slot < PROG_LEN - 1) begin
        kind   = randBits(3);
        rs     = regAddrT'(randBits(3));   // r0..r7 for dense dependencies
        rt     = regAddrT'(randBits(3));
        rd     = regAddrT'(randBits(3));
        imm    = 16'(randBits(16));
        offset = 16'(randBits(5) << 2);    // word aligned, below 128
        fn     = pickFunct();
        case (kind)
            0, 1: progMem[slot] = {OP_RTYPE, rs, rt, rd, 5'b0, fn};
            2:    progMem[slot] = {OP_ADDIU, rs, rt, imm};
            3:    progMem[slot] = {(imm[0] ? OP_ORI : OP_ANDI), rs, rt, imm};
            4:    progMem[slot] = {OP_LUI, 5'd0, rt, imm};
            5:    progMem[slot] = {OP_LW, 5'd0, rt, offset};
            6:    progMem[slot] = {OP_SW, 5'd0, rt, offset};
            default: begin
                // load, then use the loaded register right away
                rt            = (rt == 5'd0) ? 5'd1 : rt;
                progMem[slot] = {OP_LW, 5'd0, rt, offset};
                if (slot + 1 < PROG_LEN - 1) begin
                    slot          = slot + 1;
                    progMem[slot] = {OP_RTYPE, rt, rs, rd, 5'b0, fn};
                end
            end
        endcase
        slot = slot + 1;
    end
    progMem[PROG_LEN - 1] = {OP_HALT, 26'b0};
endtask

// ----------------------------------------
// instruction-level reference model
// ----------------------------------------
task automatic runModel();
    wordT     regs [32];
    wordT     dmem [DMEM_WORDS];
    wordT     instr;
    wordT     a;
    wordT     b;
    wordT     sImm;
    wordT     zImm;
    wordT     addr;
    wordT     value;
    regAddrT  dst;
    logic     writes;
    regWriteT entry;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] = '0;
    end
    for (int pcIdx = 0; pcIdx < PROG_LEN; pcIdx++) begin
        instr = progMem[pcIdx];
        if (instr[31:26] == OP_HALT) begin
            break;
        end
        a      = regs[instr[25:21]];
        b      = regs[instr[20:16]];
        sImm   = {{16{instr[15]}}, instr[15:0]};
        zImm   = {16'b0, instr[15:0]};
        addr   = a + sImm;
        dst    = instr[20:16];
        value  = '0;
        writes = 1'b1;
        case (instr[31:26])
            OP_RTYPE: begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_ADDU: value = a + b;
                    FN_SUBU: value = a - b;
                    FN_AND:  value = a & b;
                    FN_OR:   value = a | b;
                    FN_XOR:  value = a ^ b;
                    FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: value = a + sImm;
            OP_ANDI:  value = a & zImm;
            OP_ORI:   value = a | zImm;
            OP_LUI:   value = {instr[15:0], 16'b0};
            OP_LW:    value = dmem[addr[6:2]];
            OP_SW: begin
                dmem[addr[6:2]] = b;
                writes          = 1'b0;
            end
            default:  writes = 1'b0;
        endcase
        if (writes && dst != 5'd0) begin   // r0 stays zero, never reported
            regs[dst]   = value;
            entry.valid = 1'b1;
            entry.dst   = dst;
            entry.data  = value;
            expQ.push_back(entry);
        end
    end
endtask

// ==== tb/pipelineTb.sv ====
`timescale 1ns/10ps

module pipelineTb;
    import mipsPkg::*;

    localparam int PROG_LEN       = 49;              // 48 random plus halt
    localparam int LOAD_CYCLES    = 2 * PROG_LEN;    // stb cycle and ack cycle per word
    localparam int TIMEOUT_CYCLES = 4 * (PROG_LEN + LOAD_CYCLES) + 200;

    logic     clk;
    logic     reset;
    logic     halt;
    wbReqT    wbReq;
    logic     wbAck;
    regWriteT retire;
    logic     endOut;

    int errorCount;
    int retireCount;
    int expectedTotal;
    int cycleCount;

    `include "mipsModel.svh"

    pipeline dut0 (
        .clk      (clk),
        .i_reset  (reset),
        .i_halt   (halt),
        .i_wbReq  (wbReq),
        .o_wbAck  (wbAck),
        .o_retire (retire),
        .o_end    (endOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic checkRetire(input logic endSeen);
        regWriteT exp;
        if (retire.valid) begin
            retireCount++;
            if (halt) begin
                errorCount++;
                $display("[FAIL] %0t: write retired while the pipeline was frozen", $time);
            end
            if (endSeen || endOut) begin
                errorCount++;
                $display("[FAIL] %0t: write to r%0d retired after end flag", $time, retire.dst);
            end
            if (retire.dst == 5'd0) begin
                errorCount++;
                $display("[FAIL] %0t: retire names register 0", $time);
            end
            if (expQ.size() == 0) begin
                errorCount++;
                $display("[FAIL] %0t: retire r%0d with no write left in the model", $time,
                         retire.dst);
            end else begin
                exp = expQ.pop_front();
                if (retire.dst != exp.dst || retire.data != exp.data) begin
                    errorCount++;
                    $display("[FAIL] %0t: retire r%0d = %h, expected r%0d = %h", $time,
                             retire.dst, retire.data, exp.dst, exp.data);
                end
            end
        end
    endtask

    // ----------------------------------------
    // wishbone program load
    // ----------------------------------------
    task automatic loadWord(input int addr, input wordT data);
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = 1'b1;
        wbReq.adr = imemAddrT'(addr);
        wbReq.dat = data;
        @(negedge clk);
        if (wbAck !== 1'b1) begin
            errorCount++;
            $display("[FAIL] %0t: no ack in the cycle after stb, word %0d", $time, addr);
        end
        wbReq = '0;     // drop the cycle once ack is seen
        @(negedge clk);
        if (wbAck !== 1'b0) begin
            errorCount++;
            $display("[FAIL] %0t: ack high without a pending stb, word %0d", $time, addr);
        end
    endtask

    // ----------------------------------------
    // run with random freezes
    // ----------------------------------------
    task automatic runProgram();
        int   pauseLeft;
        int   tailCycles;
        logic endSeen;
        pauseLeft  = 0;
        tailCycles = 0;
        endSeen    = 1'b0;
        halt       = 1'b0;
        while (tailCycles < 12) begin   // watch a few cycles past the end flag
            @(negedge clk);
            checkRetire(endSeen);
            if (endSeen && !endOut) begin
                errorCount++;
                $display("[FAIL] %0t: end flag dropped before reset", $time);
            end
            if (endOut && !endSeen) begin
                endSeen = 1'b1;
                if (expQ.size() != 0) begin
                    errorCount++;
                    $display("[FAIL] %0t: end flag rose with %0d writes still due", $time,
                             expQ.size());
                end
            end
            if (endSeen) begin
                tailCycles++;
            end
            if (pauseLeft > 0) begin
                pauseLeft--;
            end else if (!endSeen && randBits(3) == 32'd0) begin
                pauseLeft = 1 + randBits(3);
            end
            halt = (pauseLeft > 0);
        end
    endtask

    initial begin
        reset       = 1'b1;
        halt        = 1'b1;
        wbReq       = '0;
        errorCount  = 0;
        retireCount = 0;
        lfsrState   = 32'h1ab8_0f3e;
        buildProgram();
        runModel();
        expectedTotal = expQ.size();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (wbAck !== 1'b0) begin
            errorCount++;
            $display("[FAIL] %0t: wishbone ack high after reset", $time);
        end
        if (endOut !== 1'b0 || retire.valid !== 1'b0) begin
            errorCount++;
            $display("[FAIL] %0t: end flag or retire valid high after reset", $time);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            loadWord(i, progMem[i]);
        end
        runProgram();
        if (retireCount != expectedTotal) begin
            errorCount++;
            $display("[FAIL] %0t: %0d writes retired, model expects %0d", $time,
                     retireCount, expectedTotal);
        end
        $display("errors %0d, writes retired %0d of %0d expected", errorCount, retireCount,
                 expectedTotal);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // hard limit on the whole run
    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the program never reached its end", cycleCount);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tb
common/mipsPkg.sv
fetch/instructionFetch.sv
decode/instructionDecode.sv
execute/instructionExecute.sv
memory/memoryAccess.sv
src/pipeline.sv
tb/pipelineTb.sv

// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --timing -f verilog.f --top-module pipelineTb -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
